// File: rtl/cpu_pkg.sv
// shared definitions for the five-stage integer pipeline
// widths, opcode and function codes, ALU operations,
// stage payload structs, forwarding record, APB request and
// response structs, per-stage stall vector
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASS
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [XLEN-1:0]       store_data;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  is_load;
        logic                  is_store;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  is_load;
        logic                  is_store;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]       value;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
    } mem_wb_t;

    // result offered to decode by a later stage
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic                  is_load;
    } fwd_t;

    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [XLEN-1:0] paddr;
        logic [XLEN-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
    } apb_rsp_t;

    typedef struct packed {
        logic pc;
        logic if_id;
        logic id_ex;
        logic ex_mem;
        logic mem_wb;
    } stall_t;

endpackage

// File: rtl/stage_reg.sv
// generic pipeline register
// payload type set per instance, holds on stall,
// loads an all-zero payload on reset or bubble
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // zero payload means every flag inactive
    always_ff @(posedge clk) begin
        if (rst || bubble_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

// File: rtl/pc_stall_control.sv
// program counter and stall merge
// pc advances by one word unless held,
// memory stall holds every stage, load-use stall holds
// fetch and decode and bubbles the execute input
`timescale 1ns/1ps

module pc_stall_control import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_use_stall_i,
    input  logic            mem_stall_i,
    output logic [XLEN-1:0] pc_o,
    output stall_t          stall_o,
    output logic            bubble_o
);

    always_comb begin
        stall_o  = '0;
        bubble_o = 1'b0;
        if (mem_stall_i) begin
            stall_o = '1;
        end else if (load_use_stall_i) begin
            stall_o.pc    = 1'b1;
            stall_o.if_id = 1'b1;
            bubble_o      = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_o <= RESET_PC;
        end else if (!stall_o.pc) begin
            pc_o <= pc_o + XLEN'(4);
        end
    end

endmodule

// File: rtl/decode.sv
// instruction decode
// field split, register read addresses, operand forwarding
// from execute and memory, immediate extension,
// load-use hazard detection
`timescale 1ns/1ps

module decode import cpu_pkg::*; (
    input  if_id_t                if_id_i,
    output logic [REG_ADDR_W-1:0] rs_addr_o,
    output logic [REG_ADDR_W-1:0] rt_addr_o,
    input  logic [XLEN-1:0]       rs_data_i,
    input  logic [XLEN-1:0]       rt_data_i,
    input  fwd_t                  ex_fwd_i,
    input  fwd_t                  mem_fwd_i,
    output id_ex_t                id_ex_o,
    output logic                  load_use_stall_o
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rd_field;
    logic [15:0]           imm;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    logic                  use_rs;
    logic                  use_rt;

    // register zero never takes a forwarded value
    function automatic logic hit(input fwd_t src, input logic [REG_ADDR_W-1:0] idx);
        return src.valid && (src.rd == idx) && (idx != '0);
    endfunction

    function automatic logic [XLEN-1:0] pick(input logic [REG_ADDR_W-1:0] idx,
                                             input logic [XLEN-1:0] rf_val,
                                             input fwd_t ex_src,
                                             input fwd_t mem_src);
        if (hit(ex_src, idx)) begin
            return ex_src.value;
        end
        if (hit(mem_src, idx)) begin
            return mem_src.value;
        end
        return rf_val;
    endfunction

    assign opcode    = if_id_i.instr[31:26];
    assign rs_addr_o = if_id_i.instr[25:21];
    assign rt_addr_o = if_id_i.instr[20:16];
    assign rd_field  = if_id_i.instr[15:11];
    assign funct     = if_id_i.instr[5:0];
    assign imm       = if_id_i.instr[15:0];

    assign rs_val = pick(rs_addr_o, rs_data_i, ex_fwd_i, mem_fwd_i);
    assign rt_val = pick(rt_addr_o, rt_data_i, ex_fwd_i, mem_fwd_i);

    always_comb begin
        id_ex_o = '0;
        use_rs  = 1'b0;
        use_rt  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                id_ex_o.we = 1'b1;
                case (funct)
                    FN_ADDU: id_ex_o.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_o.alu_op = ALU_SUB;
                    FN_AND:  id_ex_o.alu_op = ALU_AND;
                    FN_OR:   id_ex_o.alu_op = ALU_OR;
                    FN_SLT:  id_ex_o.alu_op = ALU_SLT;
                    default: id_ex_o.we     = 1'b0;
                endcase
                id_ex_o.op_a = rs_val;
                id_ex_o.op_b = rt_val;
                id_ex_o.rd   = rd_field;
                use_rs       = id_ex_o.we;
                use_rt       = id_ex_o.we;
            end
            OP_ORI: begin
                id_ex_o.alu_op = ALU_OR;
                id_ex_o.op_a   = rs_val;
                id_ex_o.op_b   = {16'h0000, imm};
                id_ex_o.rd     = rt_addr_o;
                id_ex_o.we     = 1'b1;
                use_rs         = 1'b1;
            end
            OP_LUI: begin
                id_ex_o.alu_op = ALU_PASS;
                id_ex_o.op_b   = {imm, 16'h0000};
                id_ex_o.rd     = rt_addr_o;
                id_ex_o.we     = 1'b1;
            end
            OP_LW: begin
                id_ex_o.alu_op  = ALU_ADD;
                id_ex_o.op_a    = rs_val;
                id_ex_o.op_b    = {{16{imm[15]}}, imm};
                id_ex_o.rd      = rt_addr_o;
                id_ex_o.we      = 1'b1;
                id_ex_o.is_load = 1'b1;
                use_rs          = 1'b1;
            end
            OP_SW: begin
                id_ex_o.alu_op     = ALU_ADD;
                id_ex_o.op_a       = rs_val;
                id_ex_o.op_b       = {{16{imm[15]}}, imm};
                id_ex_o.store_data = rt_val;
                id_ex_o.is_store   = 1'b1;
                use_rs             = 1'b1;
                use_rt             = 1'b1;
            end
            default: ;
        endcase
    end

    // load result not yet available in execute
    assign load_use_stall_o =
        (use_rs && ex_fwd_i.is_load && hit(ex_fwd_i, rs_addr_o)) ||
        (use_rt && ex_fwd_i.is_load && hit(ex_fwd_i, rt_addr_o));

endmodule

// File: rtl/reg_file.sv
// 32 x 32 register file
// two read ports, one write port from writeback,
// register zero reads as zero, same-cycle write visible on reads
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs_addr_i,
    input  logic [REG_ADDR_W-1:0] rt_addr_i,
    output logic [XLEN-1:0]       rs_data_o,
    output logic [XLEN-1:0]       rt_data_o,
    input  mem_wb_t               wb_i
);

    logic [XLEN-1:0] regs [32];

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        // write-through
        if (wb_i.we && (wb_i.rd == addr)) begin
            return wb_i.value;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    always_comb begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
    end

endmodule

// File: rtl/execute.sv
// execute stage
// ALU for the register and immediate operations,
// base plus offset for loads and stores, forwarding record
`timescale 1ns/1ps

module execute import cpu_pkg::*; (
    input  id_ex_t  id_ex_i,
    output ex_mem_t ex_mem_o,
    output fwd_t    ex_fwd_o
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  result = id_ex_i.op_a + id_ex_i.op_b;
            ALU_SUB:  result = id_ex_i.op_a - id_ex_i.op_b;
            ALU_AND:  result = id_ex_i.op_a & id_ex_i.op_b;
            ALU_OR:   result = id_ex_i.op_a | id_ex_i.op_b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}},
                                $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            ALU_PASS: result = id_ex_i.op_b;
            default:  result = '0;
        endcase
    end

    assign ex_mem_o = '{result:     result,
                        store_data: id_ex_i.store_data,
                        rd:         id_ex_i.rd,
                        we:         id_ex_i.we,
                        is_load:    id_ex_i.is_load,
                        is_store:   id_ex_i.is_store};

    // for a load the result is only the address
    assign ex_fwd_o = '{valid:   id_ex_i.we,
                        rd:      id_ex_i.rd,
                        value:   result,
                        is_load: id_ex_i.is_load};

endmodule

// File: rtl/mem_apb.sv
// memory stage with APB master
// idle/setup/access FSM, one transfer per LW or SW,
// stall request until pready, writeback and forwarding values
`timescale 1ns/1ps

module mem_apb import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  ex_mem_t  ex_mem_i,
    output apb_req_t apb_req_o,
    input  apb_rsp_t apb_rsp_i,
    output mem_wb_t  mem_wb_o,
    output fwd_t     mem_fwd_o,
    output logic     mem_stall_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_e;

    state_e          state_q;
    logic            pending;
    logic            done;
    logic [XLEN-1:0] wb_value;

    assign pending = ex_mem_i.is_load || ex_mem_i.is_store;
    assign done    = (state_q == ST_ACCESS) && apb_rsp_i.pready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:   if (pending) state_q <= ST_SETUP;
                ST_SETUP:  state_q <= ST_ACCESS;
                ST_ACCESS: if (apb_rsp_i.pready) state_q <= ST_IDLE;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    // address and data come straight from the held ex_mem register
    assign apb_req_o = '{psel:    state_q != ST_IDLE,
                         penable: state_q == ST_ACCESS,
                         pwrite:  ex_mem_i.is_store,
                         paddr:   ex_mem_i.result,
                         pwdata:  ex_mem_i.store_data};

    assign mem_stall_o = pending && !done;

    assign wb_value = ex_mem_i.is_load ? apb_rsp_i.prdata : ex_mem_i.result;

    assign mem_wb_o = '{value: wb_value, rd: ex_mem_i.rd, we: ex_mem_i.we};

    assign mem_fwd_o = '{valid:   ex_mem_i.we,
                         rd:      ex_mem_i.rd,
                         value:   wb_value,
                         is_load: ex_mem_i.is_load && !done};

endmodule

// File: rtl/cpu_top.sv
// top level of the pipelined core
// pc and stall control, four stage registers, decode,
// register file, execute, APB memory stage
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [XLEN-1:0] imem_data_i,
    output apb_req_t        apb_req_o,
    input  apb_rsp_t        apb_rsp_i
);

    logic [XLEN-1:0]       pc;
    stall_t                stall;
    logic                  bubble;
    logic                  load_use_stall;
    logic                  mem_stall;
    if_id_t                if_id_d;
    if_id_t                if_id_q;
    id_ex_t                id_ex_d;
    id_ex_t                id_ex_q;
    ex_mem_t               ex_mem_d;
    ex_mem_t               ex_mem_q;
    mem_wb_t               mem_wb_d;
    mem_wb_t               mem_wb_q;
    fwd_t                  ex_fwd;
    fwd_t                  mem_fwd;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;

    assign imem_addr_o = pc;
    assign if_id_d     = '{instr: imem_data_i, pc: pc};

    pc_stall_control #(.RESET_PC(RESET_PC)) pc_stall_control_inst (
        .clk(clk), .rst(rst),
        .load_use_stall_i(load_use_stall), .mem_stall_i(mem_stall),
        .pc_o(pc), .stall_o(stall), .bubble_o(bubble)
    );

    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk(clk), .rst(rst), .stall_i(stall.if_id), .bubble_i(1'b0),
        .d_i(if_id_d), .q_o(if_id_q)
    );

    decode decode_inst (
        .if_id_i(if_id_q),
        .rs_addr_o(rs_addr), .rt_addr_o(rt_addr),
        .rs_data_i(rs_data), .rt_data_i(rt_data),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd),
        .id_ex_o(id_ex_d), .load_use_stall_o(load_use_stall)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst(rst),
        .rs_addr_i(rs_addr), .rt_addr_i(rt_addr),
        .rs_data_o(rs_data), .rt_data_o(rt_data),
        .wb_i(mem_wb_q)
    );

    // load-use bubble enters here
    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk(clk), .rst(rst), .stall_i(stall.id_ex), .bubble_i(bubble),
        .d_i(id_ex_d), .q_o(id_ex_q)
    );

    execute execute_inst (
        .id_ex_i(id_ex_q), .ex_mem_o(ex_mem_d), .ex_fwd_o(ex_fwd)
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk(clk), .rst(rst), .stall_i(stall.ex_mem), .bubble_i(1'b0),
        .d_i(ex_mem_d), .q_o(ex_mem_q)
    );

    mem_apb mem_apb_inst (
        .clk(clk), .rst(rst),
        .ex_mem_i(ex_mem_q),
        .apb_req_o(apb_req_o), .apb_rsp_i(apb_rsp_i),
        .mem_wb_o(mem_wb_d), .mem_fwd_o(mem_fwd), .mem_stall_o(mem_stall)
    );

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst(rst), .stall_i(stall.mem_wb), .bubble_i(1'b0),
        .d_i(mem_wb_d), .q_o(mem_wb_q)
    );

endmodule

// File: sim/mem_apb_assert.sv
// APB protocol checks for the memory stage master
// penable only with psel, setup cycle before access,
// request held stable while pready is low
`timescale 1ns/1ps

module mem_apb_assert import cpu_pkg::*; (
    input logic     clk,
    input logic     rst,
    input apb_req_t apb_req_o,
    input apb_rsp_t apb_rsp_i
);

    int fail_count;

    initial fail_count = 0;

    penable_with_psel: assert property (
        @(posedge clk) disable iff (rst)
        apb_req_o.penable |-> apb_req_o.psel
    ) else begin
        $error("APB penable is high while psel is low");
        fail_count++;
    end

    setup_before_access: assert property (
        @(posedge clk) disable iff (rst)
        $rose(apb_req_o.penable) |-> $past(apb_req_o.psel && !apb_req_o.penable)
    ) else begin
        $error("APB access phase entered without a setup cycle");
        fail_count++;
    end

    // wait state keeps every request field
    stable_while_waiting: assert property (
        @(posedge clk) disable iff (rst)
        (apb_req_o.psel && apb_req_o.penable && !apb_rsp_i.pready) |=> $stable(apb_req_o)
    ) else begin
        $error("APB request changed while pready was low");
        fail_count++;
    end

endmodule

bind mem_apb mem_apb_assert mem_apb_assert_inst (
    .clk(clk),
    .rst(rst),
    .apb_req_o(apb_req_o),
    .apb_rsp_i(apb_rsp_i)
);

// File: sim/cpu_tb.sv
// testbench for the pipelined core
// clock and reset, instruction memory and APB slave models,
// pattern file reading, store checks and error summary
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam int    CLK_PERIOD    = 8;
    localparam int    RST_CYCLES    = 5;
    localparam int    STORE_TIMEOUT = 200;
    localparam int    DRAIN_CYCLES  = 20;
    localparam int    RNG_SEED      = 6156;
    localparam string PATTERN_FILE  = "sim/cpu_patterns.txt";

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } store_t;

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_data;
    apb_req_t        apb_req;
    apb_rsp_t        apb_rsp;

    logic [XLEN-1:0] imem_q [$];
    logic [XLEN-1:0] dmem [logic [XLEN-1:0]];
    store_t          expected_q [$];
    store_t          observed_q [$];
    int              wait_left;
    int              stores_checked;
    int              mismatches;
    int              timeouts;
    int              other_errors;
    int              apb_fails;

    cpu_top #(.RESET_PC('0)) cpu_top_inst (
        .clk(clk),
        .rst(rst),
        .imem_addr_o(imem_addr),
        .imem_data_i(imem_data),
        .apb_req_o(apb_req),
        .apb_rsp_i(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // no-op past the end of the program
    function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < imem_q.size()) begin
            return imem_q[idx];
        end
        return '0;
    endfunction

    // locations never written return the inverted address
    function automatic logic [XLEN-1:0] read_word(input logic [XLEN-1:0] addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return ~addr;
    endfunction

    task automatic load_patterns();
        int              fd;
        int              n;
        logic [7:0]      tag;
        logic [8*200-1:0] rest;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        store_t          s;
        fd = $fopen(PATTERN_FILE, "r");
        assert (fd != 0) else begin
            $display("Cannot open the pattern file %s", PATTERN_FILE);
            other_errors++;
            return;
        end
        while (1) begin
            tag = '0;
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                break;
            end
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "I") begin
                n = $fscanf(fd, "%h", d);
                imem_q.push_back(d);
            end else if (tag == "D") begin
                n = $fscanf(fd, "%h %h", a, d);
                dmem[a] = d;
            end else if (tag == "S") begin
                n = $fscanf(fd, "%h %h", a, d);
                s.addr = a;
                s.data = d;
                expected_q.push_back(s);
            end else begin
                $display("Unknown record type in the pattern file");
                other_errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic serve_apb();
        store_t wr;
        apb_rsp.pready = 1'b0;
        if (rst || !apb_req.psel) begin
            wait_left = 0;
        end else if (!apb_req.penable) begin
            // setup phase picks this transfer's wait states
            wait_left = int'($urandom % 4);
        end else if (wait_left > 0) begin
            wait_left--;
        end else begin
            apb_rsp.pready = 1'b1;
            if (apb_req.pwrite) begin
                dmem[apb_req.paddr] = apb_req.pwdata;
                wr.addr = apb_req.paddr;
                wr.data = apb_req.pwdata;
                observed_q.push_back(wr);
            end else begin
                apb_rsp.prdata = read_word(apb_req.paddr);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %s: expected %h, got %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic wait_for_store(input int idx, output logic found);
        int cycles;
        cycles = 0;
        while (observed_q.size() == 0 && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        found = (observed_q.size() != 0);
        assert (found) else begin
            $display("Timeout: store %0d did not complete within %0d cycles",
                     idx, STORE_TIMEOUT);
            timeouts++;
        end
    endtask

    // instruction port and APB slave, both updated just after the edge
    initial begin
        void'($urandom(RNG_SEED));
        imem_data = '0;
        apb_rsp   = '0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #1;
            imem_data = fetch_word(imem_addr);
            serve_apb();
        end
    end

    initial begin
        store_t got;
        logic   found;
        rst            = 1'b1;
        stores_checked = 0;
        mismatches     = 0;
        timeouts       = 0;
        other_errors   = 0;
        load_patterns();
        assert (expected_q.size() > 0) else begin
            $display("The pattern file holds no expected stores");
            other_errors++;
        end

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("psel", '0, XLEN'(apb_req.psel));
        check_value("imem_addr_o", '0, imem_addr);

        foreach (expected_q[i]) begin
            wait_for_store(i, found);
            if (!found) begin
                break;
            end
            got = observed_q.pop_front();
            check_value($sformatf("paddr (store %0d)", i), expected_q[i].addr, got.addr);
            check_value($sformatf("pwdata (store %0d)", i), expected_q[i].data, got.data);
            stores_checked++;
        end

        // program tail is all no-ops
        if (timeouts == 0) begin
            repeat (DRAIN_CYCLES) @(posedge clk);
            assert (observed_q.size() == 0) else begin
                $display("Unexpected store to address %h after the last expected one",
                         observed_q[0].addr);
                other_errors++;
            end
        end

        apb_fails = cpu_top_inst.mem_apb_inst.mem_apb_assert_inst.fail_count;
        $display("Errors: %0d mismatch, %0d timeout, %0d other, %0d assertion; %0d stores",
                 mismatches, timeouts, other_errors, apb_fails, stores_checked);
        if (mismatches + timeouts + other_errors + apb_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim/cpu_patterns.txt
# I <instruction word> | D <address> <data> preloads the slave memory
# S <address> <data> is an expected store, in program order
I 34011234  # ori   $1, $0, 0x1234
I AC010100  # sw    $1, 0x100($0)
I 3C02ABCD  # lui   $2, 0xabcd
I 340300FF  # ori   $3, $0, 0x00ff
I AC020104  # sw    $2, 0x104($0)
I 00432021  # addu  $4, $2, $3
I AC040108  # sw    $4, 0x108($0)
I 00612823  # subu  $5, $3, $1
I 00813024  # and   $6, $4, $1
I AC05010C  # sw    $5, 0x10c($0)
I AC060110  # sw    $6, 0x110($0)
I 00413825  # or    $7, $2, $1
I 00A3402A  # slt   $8, $5, $3
I 0065482A  # slt   $9, $3, $5
I AC070114  # sw    $7, 0x114($0)
I AC080118  # sw    $8, 0x118($0)
I AC09011C  # sw    $9, 0x11c($0)
I 340A0200  # ori   $10, $0, 0x0200
I 8D4B0000  # lw    $11, 0($10)
I 01616021  # addu  $12, $11, $1
I AC0C0120  # sw    $12, 0x120($0)
I 8D4D0004  # lw    $13, 4($10)
I 01A37021  # addu  $14, $13, $3
I AD4E0004  # sw    $14, 4($10)
I 8C0F0104  # lw    $15, 0x104($0)
I AC0F0124  # sw    $15, 0x124($0)
I AD41FFFC  # sw    $1, -4($10)
I 34108001  # ori   $16, $0, 0x8001
I AC100128  # sw    $16, 0x128($0)
D 00000200 11111111
D 00000204 7FFFFFF0
S 00000100 00001234
S 00000104 ABCD0000
S 00000108 ABCD00FF
S 0000010C FFFFEECB
S 00000110 00000034
S 00000114 ABCD1234
S 00000118 00000001
S 0000011C 00000000
S 00000120 11112345
S 00000204 800000EF
S 00000124 ABCD0000
S 000001FC 00001234
S 00000128 00008001

// File: files.f
rtl/cpu_pkg.sv
rtl/stage_reg.sv
rtl/pc_stall_control.sv
rtl/decode.sv
rtl/reg_file.sv
rtl/execute.sv
rtl/mem_apb.sv
rtl/cpu_top.sv
sim/mem_apb_assert.sv
sim/cpu_tb.sv

// File: Makefile
# Verilator lint and simulation of the pipelined core
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the summary line reports no errors
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
